//--- design/monitor_pkg.sv
// Controller monitor shared types
package monitor_pkg;

  //////////////////////////////////////////////////
  // Rule set
  //////////////////////////////////////////////////

  // Number of rules the monitor checks, fixed by the rule table
  localparam int NUM_RULES = 8;

  // Index of one rule
  typedef logic [2:0] rule_idx_t;

  // One bit per rule, bit k belongs to rule k
  typedef logic [NUM_RULES-1:0] rule_mask_t;

  //////////////////////////////////////////////////
  // Controller and bus observations
  //////////////////////////////////////////////////

  // PC source select as driven by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_NMI = 3'd4
  } pc_mux_e;

  // Controller signals sampled every cycle
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    intr_taken;
    logic    id_ld_stall;
    logic    id_invalid;
    logic    fencei_in_wb;
    logic    fencei_flush_req;
    logic    fencei_flush_ack;
    logic    nmi_is_store;
    logic    nmi_pending;
  } ctrl_obs_t;

  // Data bus signals, request and response side together
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic we;
    logic err;
  } bus_obs_t;

  //////////////////////////////////////////////////
  // Internal records and results
  //////////////////////////////////////////////////

  // Bus error tracker result
  // first_err is a pulse, latched and is_write are levels
  typedef struct packed {
    logic first_err;
    logic latched;
    logic is_write;
  } err_state_t;

  // Inputs of one rule lane
  typedef struct packed {
    logic trigger;
    logic forbid_now;
    logic forbid_next;
  } rule_obs_t;

  // Violation log result, the count travels on its own port
  typedef struct packed {
    rule_mask_t flags;
    logic       first_valid;
    rule_idx_t  first_rule;
  } log_state_t;

endpackage

//--- design/bus_error_tracker.sv
// Data bus error tracker
`timescale 1ns/1ps

module bus_error_tracker
  import monitor_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  bus_obs_t   bus_i,
  input  logic       nmi_clear_i,
  output err_state_t err_o
);

  // A request only counts once it has been granted
  logic       granted;
  // Number of transactions waiting for their response
  logic [1:0] cnt_q;
  // Write flags of outstanding transactions, entry 1 is the older one
  logic [1:0] type_q;
  logic       latched_q;
  logic       is_write_q;
  logic       first_err;
  logic       oldest_we;

  assign granted = bus_i.req && bus_i.gnt;

  // Only the first error response after a clear is of interest
  assign first_err = bus_i.rvalid && bus_i.err && !latched_q;

  // With a single transaction in flight the oldest one sits in entry 0
  assign oldest_we = (cnt_q == 2'd1) ? type_q[0] : type_q[1];

  //////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else if (granted && !bus_i.rvalid) begin
      cnt_q <= cnt_q + 2'd1;
    end else if (!granted && bus_i.rvalid) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  // New write flag enters entry 0
  // When two are in flight and one retires, the history shifts so the newer one becomes oldest
  always_ff @(posedge clk) begin
    if (granted && (!bus_i.rvalid || cnt_q == 2'd2)) begin
      type_q <= {type_q[0], bus_i.we};
    end else if (granted) begin
      type_q[0] <= bus_i.we;
    end
  end

  //////////////////////////////////////////////////
  // First error latch
  //////////////////////////////////////////////////

  // The latch holds until the core takes the NMI trap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      latched_q  <= 1'b0;
      is_write_q <= 1'b0;
    end else if (first_err) begin
      latched_q  <= 1'b1;
      is_write_q <= oldest_we;
    end else if (nmi_clear_i) begin
      latched_q  <= 1'b0;
    end
  end

  assign err_o.first_err = first_err;
  assign err_o.latched   = latched_q;
  assign err_o.is_write  = is_write_q;

  // The core never issues more than two data transactions at once
  a_max_two_outstanding :
    assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= 2'd2)
      else $error("bus_error_tracker: more than two outstanding transactions");

endmodule

//--- design/rule_decoder.sv
// Rule trigger decoder
`timescale 1ns/1ps

module rule_decoder
  import monitor_pkg::*;
(
  input  ctrl_obs_t                 ctrl_i,
  input  err_state_t                err_i,
  output rule_obs_t [NUM_RULES-1:0] rules_o,
  output logic                      nmi_trap_o
);

  // PC set events decoded from the mux select
  logic branch_set;
  logic jump_set;
  // NMI flags that disagree with the tracker's latched error
  logic nmi_mismatch;
  logic req_no_ack;
  logic req_and_ack;

  assign branch_set = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BRANCH);

  // An mret counts as a jump for the back-to-back rule
  assign jump_set = ctrl_i.pc_set &&
                    ((ctrl_i.pc_mux == PC_JUMP) || (ctrl_i.pc_mux == PC_MRET));

  assign nmi_trap_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_TRAP_NMI);

  assign nmi_mismatch = (ctrl_i.nmi_is_store != err_i.is_write) || !ctrl_i.nmi_pending;

  assign req_no_ack  = ctrl_i.fencei_flush_req && !ctrl_i.fencei_flush_ack;
  assign req_and_ack = ctrl_i.fencei_flush_req && ctrl_i.fencei_flush_ack;

  //////////////////////////////////////////////////
  // Rule table
  //////////////////////////////////////////////////

  always_comb begin
    // No back-to-back branch
    rules_o[0] = '{trigger: branch_set, forbid_now: 1'b0, forbid_next: branch_set};
    // No back-to-back jump or mret
    rules_o[1] = '{trigger: jump_set, forbid_now: 1'b0, forbid_next: jump_set};
    // Interrupt-taken event lasts one cycle
    rules_o[2] = '{trigger:     ctrl_i.intr_taken,
                   forbid_now:  1'b0,
                   forbid_next: ctrl_i.intr_taken};
    // Load stall is a subset of ID invalid
    rules_o[3] = '{trigger:     ctrl_i.id_ld_stall,
                   forbid_now:  !ctrl_i.id_invalid,
                   forbid_next: 1'b0};
    // Flush request only with a fence.i in writeback
    rules_o[4] = '{trigger:     ctrl_i.fencei_flush_req,
                   forbid_now:  !ctrl_i.fencei_in_wb,
                   forbid_next: 1'b0};
    // Request may not drop before it is acknowledged
    rules_o[5] = '{trigger:     req_no_ack,
                   forbid_now:  1'b0,
                   forbid_next: !ctrl_i.fencei_flush_req};
    // Request must drop right after the handshake
    rules_o[6] = '{trigger:     req_and_ack,
                   forbid_now:  1'b0,
                   forbid_next: ctrl_i.fencei_flush_req};
    // Controller NMI flags follow the first bus error one cycle later
    rules_o[7] = '{trigger: err_i.first_err, forbid_now: 1'b0, forbid_next: nmi_mismatch};
  end

endmodule

//--- design/rule_lane.sv
// Single rule checker lane
`timescale 1ns/1ps

module rule_lane
  import monitor_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  rule_obs_t rule_i,
  output logic      violation_o
);

  // Trigger seen in the previous cycle
  logic trig_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_q <= 1'b0;
    end else begin
      trig_q <= rule_i.trigger;
    end
  end

  // Same-cycle part and next-cycle part of the rule
  // Both may hit at once, which still gives a single pulse
  assign violation_o = (rule_i.trigger && rule_i.forbid_now) ||
                       (trig_q && rule_i.forbid_next);

endmodule

//--- design/violation_log.sv
// Sticky violation log
`timescale 1ns/1ps

module violation_log
  import monitor_pkg::*;
#(
  parameter int COUNT_W = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear_i,
  input  rule_mask_t         viol_i,
  output log_state_t         state_o,
  output logic [COUNT_W-1:0] count_o
);

  // Sum is wide enough for the count plus up to eight new hits
  localparam int SUM_W = COUNT_W + 4;
  localparam logic [COUNT_W-1:0] CNT_MAX = '1;

  log_state_t         state_q;
  logic [COUNT_W-1:0] count_q;
  logic [COUNT_W-1:0] count_base;
  logic [3:0]         hits;
  logic [SUM_W-1:0]   sum;
  rule_idx_t          lowest;
  // After a clear the log restarts from this cycle's pulses alone
  logic               restart;

  //////////////////////////////////////////////////
  // Per-cycle decode of the pulse mask
  //////////////////////////////////////////////////

  // Population count and lowest set index in one pass
  always_comb begin
    hits   = 4'd0;
    lowest = '0;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      hits = hits + 4'(viol_i[i]);
      if (viol_i[i]) lowest = rule_idx_t'(i);
    end
  end

  assign restart    = clear_i || !state_q.first_valid;
  assign count_base = clear_i ? '0 : count_q;
  assign sum        = SUM_W'(count_base) + SUM_W'(hits);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
      count_q <= '0;
    end else begin
      state_q.flags <= clear_i ? viol_i : (state_q.flags | viol_i);
      // First rule only moves when the log is empty
      if (restart) begin
        state_q.first_valid <= |viol_i;
        state_q.first_rule  <= lowest;
      end
      count_q <= (sum > SUM_W'(CNT_MAX)) ? CNT_MAX : sum[COUNT_W-1:0];
    end
  end

  assign state_o = state_q;
  assign count_o = count_q;

  // Flags and first-rule record are updated together and may never drift apart
  a_flags_imply_first :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (|state_q.flags) |-> state_q.first_valid)
      else $error("violation_log: flag set without a first rule");

endmodule

//--- design/ctrl_monitor_top.sv
// Controller runtime monitor top level
`timescale 1ns/1ps

module ctrl_monitor_top
  import monitor_pkg::*;
#(
  parameter int COUNT_W = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  ctrl_obs_t          ctrl_i,
  input  bus_obs_t           bus_i,
  input  logic               clear_i,
  output log_state_t         state_o,
  output logic [COUNT_W-1:0] count_o
);

  // NMI trap seen by the decoder, clears the tracker's error latch
  logic                      nmi_trap;
  err_state_t                err_state;
  rule_obs_t [NUM_RULES-1:0] rules;
  rule_mask_t                viol;

  //////////////////////////////////////////////////
  // Observation front end
  //////////////////////////////////////////////////

  bus_error_tracker u_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_i       (bus_i),
    .nmi_clear_i (nmi_trap),
    .err_o       (err_state)
  );

  rule_decoder u_decoder (
    .ctrl_i     (ctrl_i),
    .err_i      (err_state),
    .rules_o    (rules),
    .nmi_trap_o (nmi_trap)
  );

  //////////////////////////////////////////////////
  // Rule lanes and log
  //////////////////////////////////////////////////

  // Each lane keeps its own history so rules overlap freely
  for (genvar k = 0; k < NUM_RULES; k++) begin : g_lane
    rule_lane u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .rule_i      (rules[k]),
      .violation_o (viol[k])
    );
  end

  violation_log #(
    .COUNT_W (COUNT_W)
  ) u_log (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (clear_i),
    .viol_i  (viol),
    .state_o (state_o),
    .count_o (count_o)
  );

endmodule

//--- verif/ctrl_monitor_checks.svh
// Monitor testbench compare tasks
`ifndef CTRL_MONITOR_CHECKS_SVH
`define CTRL_MONITOR_CHECKS_SVH

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// Log state holds the sticky flags and the first-rule record
task automatic check_state(input int row, input log_state_t got, input log_state_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED state_o row %0d: got 0x%h expected 0x%h", row, got, exp);
    $display("  flags 0x%h/0x%h first_valid %0h/%0h first_rule 0x%h/0x%h",
             got.flags, exp.flags, got.first_valid, exp.first_valid,
             got.first_rule, exp.first_rule);
    $display("Test FAILED");
    $fatal(1, "log state mismatch");
  end
endtask

// Saturating violation count
task automatic check_count(input int row, input logic [COUNT_W-1:0] got,
                           input logic [COUNT_W-1:0] exp);
  if (got !== exp) begin
    $display("CHECK FAILED count_o row %0d: got 0x%h expected 0x%h", row, got, exp);
    $display("Test FAILED");
    $fatal(1, "violation count mismatch");
  end
endtask

//////////////////////////////////////////////////
// Pseudo-random source
//////////////////////////////////////////////////

// Linear congruential step, the upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- verif/ctrl_monitor_tb.sv
// Controller monitor testbench
`timescale 1ns/1ps

module ctrl_monitor_tb
  import monitor_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int COUNT_W      = 4;
  localparam int CNT_SAT      = (1 << COUNT_W) - 1;
  localparam int TABLE_DEPTH  = 80;
  localparam int SEED         = 53335;
  // Reset, every table slot and the drain cycles, plus some slack
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TABLE_DEPTH + 4) * CLK_PERIOD + 100;

  // One table row whose expectation is the log state after the row is taken
  typedef struct packed {
    logic               idle;
    ctrl_obs_t          ctrl;
    bus_obs_t           bus;
    logic               clear;
    log_state_t         exp_state;
    logic [COUNT_W-1:0] exp_count;
  } row_t;

  logic               clk = 1'b0;
  logic               rst_n;
  ctrl_obs_t          ctrl_i;
  bus_obs_t           bus_i;
  logic               clear_i;
  log_state_t         state_o;
  logic [COUNT_W-1:0] count_o;

  row_t               table_mem [TABLE_DEPTH];
  int                 n_rows;
  logic [31:0]        rand_state;
  // Running expectation used while the table is built
  log_state_t         exp_state;
  logic [COUNT_W-1:0] exp_count;

  `include "ctrl_monitor_checks.svh"

  ctrl_monitor_top #(
    .COUNT_W (COUNT_W)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl_i  (ctrl_i),
    .bus_i   (bus_i),
    .clear_i (clear_i),
    .state_o (state_o),
    .count_o (count_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus builders
  //////////////////////////////////////////////////

  function automatic ctrl_obs_t pc_event(input pc_mux_e mux);
    ctrl_obs_t c;
    c        = '0;
    c.pc_set = 1'b1;
    c.pc_mux = mux;
    return c;
  endfunction

  function automatic ctrl_obs_t core_events(input logic intr, input logic stall,
                                            input logic invalid);
    ctrl_obs_t c;
    c             = '0;
    c.intr_taken  = intr;
    c.id_ld_stall = stall;
    c.id_invalid  = invalid;
    return c;
  endfunction

  function automatic ctrl_obs_t fence_step(input logic in_wb, input logic req, input logic ack);
    ctrl_obs_t c;
    c                  = '0;
    c.fencei_in_wb     = in_wb;
    c.fencei_flush_req = req;
    c.fencei_flush_ack = ack;
    return c;
  endfunction

  function automatic ctrl_obs_t nmi_flags(input logic pending, input logic is_store);
    ctrl_obs_t c;
    c              = '0;
    c.nmi_pending  = pending;
    c.nmi_is_store = is_store;
    return c;
  endfunction

  // Granted request in a single cycle
  function automatic bus_obs_t bus_grant(input logic we);
    bus_obs_t b;
    b     = '0;
    b.req = 1'b1;
    b.gnt = 1'b1;
    b.we  = we;
    return b;
  endfunction

  function automatic bus_obs_t bus_response(input logic err);
    bus_obs_t b;
    b        = '0;
    b.rvalid = 1'b1;
    b.err    = err;
    return b;
  endfunction

  task automatic expect_log(input rule_mask_t flags, input logic fv, input rule_idx_t fr,
                            input logic [COUNT_W-1:0] cnt);
    exp_state.flags       = flags;
    exp_state.first_valid = fv;
    exp_state.first_rule  = fr;
    exp_count             = cnt;
  endtask

  task automatic store_row(input row_t r);
    if (n_rows >= TABLE_DEPTH) begin
      $display("Stimulus table is full, more rows than the table can hold");
      $display("Test FAILED");
      $fatal(1, "table overflow");
    end else begin
      table_mem[n_rows] = r;
      n_rows++;
    end
  endtask

  task automatic add_row(input ctrl_obs_t c, input bus_obs_t b, input logic clr);
    row_t r;
    r.idle      = 1'b0;
    r.ctrl      = c;
    r.bus       = b;
    r.clear     = clr;
    r.exp_state = exp_state;
    r.exp_count = exp_count;
    store_row(r);
  endtask

  // Filler row whose free fields get randomized when it is applied
  task automatic add_idle();
    row_t r;
    r           = '0;
    r.idle      = 1'b1;
    r.exp_state = exp_state;
    r.exp_count = exp_count;
    store_row(r);
  endtask

  // Only fields that no rule looks at in an idle cycle are touched
  // Requests, responses, stalls and PC sets all stay low
  function automatic row_t vary_idle(input row_t r);
    row_t v;
    v = r;
    if (r.idle) begin
      rand_state            = lcg_next(rand_state);
      v.ctrl.pc_mux           = pc_mux_e'({1'b0, rand_state[17:16]});
      v.ctrl.id_invalid       = rand_state[18];
      v.ctrl.fencei_in_wb     = rand_state[19];
      v.ctrl.fencei_flush_ack = rand_state[20];
      v.ctrl.nmi_is_store     = rand_state[21];
      v.ctrl.nmi_pending      = rand_state[22];
      v.bus.gnt               = rand_state[23];
      v.bus.we                = rand_state[24];
      v.bus.err               = rand_state[25];
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic build_table();
    ctrl_obs_t c;
    int        k;
    n_rows = 0;
    expect_log('0, 1'b0, '0, '0);
    // Quiet start, then two branches with a gap between them
    add_idle();
    add_idle();
    add_row(pc_event(PC_BRANCH), '0, 1'b0);
    add_idle();
    add_row(pc_event(PC_BRANCH), '0, 1'b0);
    add_idle();
    // Back-to-back branch, then an mret right after a jump
    add_row(pc_event(PC_BRANCH), '0, 1'b0);
    expect_log(8'h01, 1'b1, 3'd0, 4'd1);
    add_row(pc_event(PC_BRANCH), '0, 1'b0);
    add_idle();
    add_row(pc_event(PC_JUMP), '0, 1'b0);
    expect_log(8'h03, 1'b1, 3'd0, 4'd2);
    add_row(pc_event(PC_MRET), '0, 1'b0);
    add_idle();
    // Two-cycle interrupt-taken event
    add_row(core_events(1'b1, 1'b0, 1'b0), '0, 1'b0);
    expect_log(8'h07, 1'b1, 3'd0, 4'd3);
    add_row(core_events(1'b1, 1'b0, 1'b0), '0, 1'b0);
    add_idle();
    // Load stall outside ID invalid
    expect_log(8'h0f, 1'b1, 3'd0, 4'd4);
    add_row(core_events(1'b0, 1'b1, 1'b0), '0, 1'b0);
    add_idle();
    // Legal stall first, then two rules hit in one cycle
    add_row(core_events(1'b1, 1'b1, 1'b1), '0, 1'b0);
    expect_log(8'h0f, 1'b1, 3'd0, 4'd6);
    add_row(core_events(1'b1, 1'b1, 1'b0), '0, 1'b0);
    add_idle();
    // Well-behaved fence.i flush handshake
    add_row(fence_step(1'b1, 1'b1, 1'b0), '0, 1'b0);
    add_row(fence_step(1'b1, 1'b1, 1'b1), '0, 1'b0);
    add_idle();
    // Request outside writeback, then dropped without an acknowledge
    expect_log(8'h1f, 1'b1, 3'd0, 4'd7);
    add_row(fence_step(1'b0, 1'b1, 1'b0), '0, 1'b0);
    expect_log(8'h3f, 1'b1, 3'd0, 4'd8);
    add_row(fence_step(1'b0, 1'b0, 1'b0), '0, 1'b0);
    add_idle();
    // Request still high after the handshake
    add_row(fence_step(1'b1, 1'b1, 1'b1), '0, 1'b0);
    expect_log(8'h7f, 1'b1, 3'd0, 4'd9);
    add_row(fence_step(1'b1, 1'b1, 1'b0), '0, 1'b0);
    add_row(fence_step(1'b1, 1'b1, 1'b1), '0, 1'b0);
    add_idle();
    // Write then load where the write errors and the NMI flags agree
    add_row('0, bus_grant(1'b1), 1'b0);
    add_row('0, bus_grant(1'b0), 1'b0);
    add_row('0, bus_response(1'b1), 1'b0);
    add_row(nmi_flags(1'b1, 1'b1), bus_response(1'b0), 1'b0);
    c              = pc_event(PC_TRAP_NMI);
    c.nmi_pending  = 1'b1;
    c.nmi_is_store = 1'b1;
    add_row(c, '0, 1'b0);
    expect_log('0, 1'b0, '0, '0);
    add_row('0, '0, 1'b1);
    // Same sequence with the controller reporting a load instead
    add_row('0, bus_grant(1'b1), 1'b0);
    add_row('0, bus_grant(1'b0), 1'b0);
    add_row('0, bus_response(1'b1), 1'b0);
    expect_log(8'h80, 1'b1, 3'd7, 4'd1);
    add_row(nmi_flags(1'b1, 1'b0), bus_response(1'b0), 1'b0);
    c             = pc_event(PC_TRAP_NMI);
    c.nmi_pending = 1'b1;
    add_row(c, '0, 1'b0);
    add_idle();
    // Clear, then a long branch run drives the count into saturation
    expect_log('0, 1'b0, '0, '0);
    add_row('0, '0, 1'b1);
    add_idle();
    add_row(pc_event(PC_BRANCH), '0, 1'b0);
    for (k = 1; k <= CNT_SAT + 1; k++) begin
      expect_log(8'h01, 1'b1, 3'd0, (k > CNT_SAT) ? COUNT_W'(CNT_SAT) : COUNT_W'(k));
      add_row(pc_event(PC_BRANCH), '0, 1'b0);
    end
    // A hit in the clear cycle survives the clear
    expect_log(8'h08, 1'b1, 3'd3, 4'd1);
    add_row(core_events(1'b0, 1'b1, 1'b0), '0, 1'b1);
    add_idle();
    expect_log('0, 1'b0, '0, '0);
    add_row('0, '0, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int   i;
    row_t r;
    rand_state = SEED;
    ctrl_i     <= '0;
    bus_i      <= '0;
    clear_i    <= 1'b0;
    rst_n      <= 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Row i goes in on an edge and the row before it is checked half a cycle later
    for (i = 0; i < n_rows; i++) begin
      @(posedge clk);
      r = vary_idle(table_mem[i]);
      ctrl_i  <= r.ctrl;
      bus_i   <= r.bus;
      clear_i <= r.clear;
      if (i > 0) begin
        @(negedge clk);
        check_state(i - 1, state_o, table_mem[i - 1].exp_state);
        check_count(i - 1, count_o, table_mem[i - 1].exp_count);
      end
    end
    // Drain the last row
    @(posedge clk);
    ctrl_i  <= '0;
    bus_i   <= '0;
    clear_i <= 1'b0;
    @(negedge clk);
    check_state(n_rows - 1, state_o, table_mem[n_rows - 1].exp_state);
    check_count(n_rows - 1, count_o, table_mem[n_rows - 1].exp_count);
    $display("Test OK");
    $finish;
  end

  // Watchdog against a stuck run
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the table did not finish", WATCHDOG_NS);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- ctrl_monitor_top.f
+incdir+verif
design/monitor_pkg.sv
design/bus_error_tracker.sv
design/rule_decoder.sv
design/rule_lane.sv
design/violation_log.sv
design/ctrl_monitor_top.sv
verif/ctrl_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the controller monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=ctrl_monitor_sim
LOG=sim.log

verilator --binary --timing --assert \
  --top-module ctrl_monitor_tb \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN" \
  -f ctrl_monitor_top.f
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "ERROR: simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
